/* all.f */
verilog/xoodoo_pkg.sv
verilog/xoodoo_round.sv
verilog/xoodoo_sequencer.sv
verilog/xoodoo_state_reg.sv
verilog/xoodoo_core.sv
bench/xoodoo_checker.sv
bench/xoodoo_sva.sv
bench/xoodoo_tb.sv

/* Bender.yml */
package:
  name: xoodoo

sources:
  - verilog/xoodoo_pkg.sv
  - verilog/xoodoo_round.sv
  - verilog/xoodoo_sequencer.sv
  - verilog/xoodoo_state_reg.sv
  - verilog/xoodoo_core.sv
  - target: simulation
    files:
      - bench/xoodoo_checker.sv
      - bench/xoodoo_sva.sv
      - bench/xoodoo_tb.sv

/* bench/xoodoo_tb.sv */
`default_nettype none

module xoodoo_tb;
        timeunit 1ns;
        timeprecision 1ps;

        localparam int NUM_PERMS    = 40;
        localparam int DONE_TIMEOUT = 20;

        logic               eph1;
        logic               reset;
        logic               start;
        xoodoo_pkg::state_t state_in;
        xoodoo_pkg::state_t state_out;
        logic               busy;
        logic               done;
        int                 error_count;
        int                 result_count;
        int                 timeout_count;

        xoodoo_core i_xoodoo_core (
                .eph1      (eph1),
                .reset     (reset),
                .start     (start),
                .state_in  (state_in),
                .state_out (state_out),
                .busy      (busy),
                .done      (done)
        );

        xoodoo_checker i_checker (
                .eph1         (eph1),
                .reset        (reset),
                .start        (start),
                .state_in     (state_in),
                .state_out    (state_out),
                .busy         (busy),
                .done         (done),
                .error_count  (error_count),
                .result_count (result_count)
        );

        initial begin
                eph1 = 1'b0;
                forever #20 eph1 = ~eph1;
        end

        // ----------------------------------------------------------------------
        // Stimulus helpers
        // ----------------------------------------------------------------------
        function automatic xoodoo_pkg::state_t random_state();
                xoodoo_pkg::state_t s;
                for (int i = 0; i < 12; i++)
                        s[i / 4][i % 4] = $urandom();
                return s;
        endfunction

        // Inputs change 2 ns after the rising edge
        task automatic next_drive_slot();
                @(posedge eph1);
                #2;
        endtask

        task automatic send_start(input xoodoo_pkg::state_t s);
                next_drive_slot();
                start = 1'b1;
                state_in = s;
                next_drive_slot();
                start = 1'b0;
                state_in = random_state();
        endtask

        task automatic wait_for_done();
                int cycles;
                cycles = 0;
                @(negedge eph1);
                while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
                        @(negedge eph1);
                        cycles++;
                end
                if (done !== 1'b1) begin
                        timeout_count++;
                        $display("Timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
                end
        endtask

        // ----------------------------------------------------------------------
        // Main sequence
        // ----------------------------------------------------------------------
        initial begin
                int gap;
                int mode;
                int sva_errors;
                bit failed;
                reset = 1'b1;
                start = 1'b0;
                state_in = '0;
                timeout_count = 0;
                void'($urandom(32'h2b8a_9a9f));
                repeat (10) @(posedge eph1);
                #2 reset = 1'b0;

                for (int n = 0; n < NUM_PERMS; n++) begin
                        gap = $urandom_range(3, 0);
                        mode = $urandom_range(2, 0);
                        repeat (gap) next_drive_slot();
                        send_start(random_state());
                        // Mode 1 pulses start once during the run
                        if (mode == 1) begin
                                start = 1'b1;
                                state_in = random_state();
                                next_drive_slot();
                                start = 1'b0;
                        end
                        // Mode 2 holds start until it is taken in the done cycle
                        if (mode == 2) begin
                                start = 1'b1;
                                state_in = random_state();
                                wait_for_done();
                                next_drive_slot();
                                start = 1'b0;
                        end
                        wait_for_done();
                end

                // Abandon a run with reset, then restart
                send_start(random_state());
                next_drive_slot();
                reset = 1'b1;
                next_drive_slot();
                reset = 1'b0;
                repeat (6) next_drive_slot();
                send_start(random_state());
                wait_for_done();
                repeat (2) next_drive_slot();

                sva_errors = i_xoodoo_core.i_sva.assert_errors;
                if (result_count == 0)
                        $display("No permutation result reached the checker");
                failed = (error_count != 0) || (timeout_count != 0) || (result_count == 0)
                         || (sva_errors != 0);
                $display("%0d mismatches, %0d assert errors, %0d timeouts, %0d results checked",
                         error_count, sva_errors, timeout_count, result_count);
                if (failed)
                        $display("sim failed");
                else
                        $display("sim passed");
                $finish;
        end

endmodule

`default_nettype wire

/* bench/xoodoo_sva.sv */
`default_nettype none

// Protocol properties of the control strobes
module xoodoo_sva (
        input logic               eph1,
        input logic               reset,
        input logic               busy,
        input logic               done,
        input xoodoo_pkg::state_t state_out
);
        timeunit 1ns;
        timeprecision 1ps;

        // Failed assertions so far, read by the testbench top
        int assert_errors;

        initial assert_errors = 0;

        // Single cycle done
        a_done_once: assert property (@(posedge eph1) disable iff (reset) done |=> !done)
                else begin
                        assert_errors++;
                        $error("done stayed high for two cycles");
                end

        a_done_after_busy: assert property (@(posedge eph1) disable iff (reset)
                $rose(done) |-> $past(busy))
                else begin
                        assert_errors++;
                        $error("done rose without a run before it");
                end

        a_busy_done_excl: assert property (@(posedge eph1) disable iff (reset) !(busy && done))
                else begin
                        assert_errors++;
                        $error("busy and done high together");
                end

        // Everything cleared one cycle after reset
        a_reset_clear: assert property (@(posedge eph1)
                reset |=> (!busy && !done && state_out == '0))
                else begin
                        assert_errors++;
                        $error("outputs not cleared after reset");
                end

endmodule

bind xoodoo_core xoodoo_sva i_sva (
        .eph1      (eph1),
        .reset     (reset),
        .busy      (busy),
        .done      (done),
        .state_out (state_out)
);

`default_nettype wire

/* bench/xoodoo_checker.sv */
`default_nettype none

// Watches the core ports and compares them with a cycle model
module xoodoo_checker #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic               eph1,
        input  logic               reset,
        input  logic               start,
        input  xoodoo_pkg::state_t state_in,
        input  xoodoo_pkg::state_t state_out,
        input  logic               busy,
        input  logic               done,
        output int                 error_count,
        output int                 result_count
);
        timeunit 1ns;
        timeprecision 1ps;

        localparam int NUM_CYCLES = xoodoo_pkg::NUM_ROUNDS / ROUNDS_PER_CYCLE;

        // Expected behaviour, updated on the rising edge
        bit                 armed;
        bit                 exp_busy;
        bit                 exp_done;
        bit                 out_known;
        int                 run_ctr;
        xoodoo_pkg::state_t exp_out;
        xoodoo_pkg::state_t pending;

        // ----------------------------------------------------------------------
        // Reference model of the permutation
        // ----------------------------------------------------------------------

        // Rotation by taking a window out of the doubled lane
        function automatic xoodoo_pkg::lane_t rot(input xoodoo_pkg::lane_t v, input int n);
                logic [63:0] w;
                w = {v, v} >> (xoodoo_pkg::LANE_BITS - n);
                return w[31:0];
        endfunction

        function automatic xoodoo_pkg::state_t model_round(input xoodoo_pkg::state_t s,
                                                           input xoodoo_pkg::lane_t rc);
                xoodoo_pkg::lane_t  a [3][4];
                xoodoo_pkg::lane_t  b [3][4];
                xoodoo_pkg::lane_t  p [4];
                xoodoo_pkg::state_t r;
                for (int y = 0; y < 3; y++)
                        for (int x = 0; x < 4; x++)
                                a[y][x] = s[y][x];
                // Theta, parity of column x-1 at two offsets
                for (int x = 0; x < 4; x++)
                        p[x] = a[0][x] ^ a[1][x] ^ a[2][x];
                for (int y = 0; y < 3; y++)
                        for (int x = 0; x < 4; x++)
                                b[y][x] = a[y][x] ^ rot(p[(x + 3) % 4], 5)
                                          ^ rot(p[(x + 3) % 4], 14);
                // Rho-west then iota
                for (int x = 0; x < 4; x++) begin
                        a[0][x] = b[0][x];
                        a[1][x] = b[1][(x + 3) % 4];
                        a[2][x] = rot(b[2][x], 11);
                end
                a[0][0] = a[0][0] ^ rc;
                // Chi
                for (int y = 0; y < 3; y++)
                        for (int x = 0; x < 4; x++)
                                b[y][x] = a[y][x] ^ (~a[(y + 1) % 3][x] & a[(y + 2) % 3][x]);
                // Rho-east
                for (int x = 0; x < 4; x++) begin
                        r[0][x] = b[0][x];
                        r[1][x] = rot(b[1][x], 1);
                        r[2][x] = rot(b[2][(x + 2) % 4], 8);
                end
                return r;
        endfunction

        function automatic xoodoo_pkg::state_t permute(input xoodoo_pkg::state_t s);
                xoodoo_pkg::state_t t;
                t = s;
                for (int i = 0; i < xoodoo_pkg::NUM_ROUNDS; i++)
                        t = model_round(t, xoodoo_pkg::round_constant(xoodoo_pkg::round_idx_t'(i)));
                return t;
        endfunction

        task automatic compare_value(input string name, input logic [383:0] expv,
                                     input logic [383:0] actv);
                if (actv !== expv) begin
                        error_count++;
                        $display("Fail %s: expected %0h, got %0h", name, expv, actv);
                end
        endtask

        initial begin
                error_count = 0;
                result_count = 0;
                armed = 0;
        end

        // ----------------------------------------------------------------------
        // Cycle model, inputs are stable at the rising edge
        // ----------------------------------------------------------------------
        always @(posedge eph1) begin
                if (reset) begin
                        armed = 1;
                        exp_busy = 0;
                        exp_done = 0;
                        run_ctr = 0;
                        exp_out = '0;
                        out_known = 1;
                end else if (armed) begin
                        exp_done = 0;
                        // Accept only when idle, the done cycle included
                        if (!exp_busy && start) begin
                                pending = permute(state_in);
                                run_ctr = 0;
                                exp_busy = 1;
                                out_known = 0;
                        end
                        if (exp_busy) begin
                                run_ctr++;
                                if (run_ctr == NUM_CYCLES) begin
                                        exp_busy = 0;
                                        exp_done = 1;
                                        exp_out = pending;
                                        out_known = 1;
                                end
                        end
                end
        end

        // Outputs compared mid cycle
        always @(negedge eph1) begin
                if (armed) begin
                        compare_value("busy", 384'(exp_busy), 384'(busy));
                        compare_value("done", 384'(exp_done), 384'(done));
                        // Intermediate round states are not checked
                        if (out_known)
                                compare_value("state_out", exp_out, state_out);
                        if (exp_done)
                                result_count++;
                end
        end

endmodule

`default_nettype wire

/* verilog/xoodoo_core.sv */
`default_nettype none

// Standalone Xoodoo permutation, ROUNDS_PER_CYCLE rounds per clock
module xoodoo_core #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic               eph1,
        input  logic               reset,
        input  logic               start,
        input  xoodoo_pkg::state_t state_in,
        output xoodoo_pkg::state_t state_out,
        output logic               busy,
        output logic               done
);

        // Chain taps; entry 0 is the sequencer output, last entry feeds the register
        xoodoo_pkg::state_t                       chain [ROUNDS_PER_CYCLE+1];
        xoodoo_pkg::lane_t [ROUNDS_PER_CYCLE-1:0] rc;
        logic                                     advance;
        logic                                     last;

        // ----------------------------------------------------------------------
        // Control
        // ----------------------------------------------------------------------
        xoodoo_sequencer #(
                .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
        ) i_sequencer (
                .eph1     (eph1),
                .reset    (reset),
                .start    (start),
                .state_in (state_in),
                .state_fb (state_out),
                .round_in (chain[0]),
                .rc       (rc),
                .advance  (advance),
                .last     (last),
                .busy     (busy)
        );

        // ----------------------------------------------------------------------
        // Unrolled rounds
        // ----------------------------------------------------------------------
        for (genvar k = 0; k < ROUNDS_PER_CYCLE; k++) begin : g_round
                xoodoo_round i_round (
                        .state_in  (chain[k]),
                        .rc        (rc[k]),
                        .state_out (chain[k+1])
                );
        end

        // ----------------------------------------------------------------------
        // State register and done
        // ----------------------------------------------------------------------
        xoodoo_state_reg i_state_reg (
                .eph1      (eph1),
                .reset     (reset),
                .advance   (advance),
                .last      (last),
                .round_out (chain[ROUNDS_PER_CYCLE]),
                .state_out (state_out),
                .done      (done)
        );

endmodule

`default_nettype wire

/* verilog/xoodoo_state_reg.sv */
`default_nettype none

// Holds the permutation state at the end of the round chain
module xoodoo_state_reg (
        input  logic               eph1,
        input  logic               reset,
        input  logic               advance,
        input  logic               last,
        input  xoodoo_pkg::state_t round_out,
        output xoodoo_pkg::state_t state_out,
        output logic               done
);

        // ----------------------------------------------------------------------
        // State register
        // ----------------------------------------------------------------------

        // Reset kills the state; value held whenever advance is low
        always_ff @(posedge eph1) begin
                if (reset) begin
                        state_out <= '0;
                end else if (advance) begin
                        state_out <= round_out;
                end
        end

        // ----------------------------------------------------------------------
        // Done strobe
        // ----------------------------------------------------------------------

        // One clock, lines up with the first cycle of the finished state
        always_ff @(posedge eph1) begin
                if (reset) begin
                        done <= 1'b0;
                end else begin
                        done <= last & advance;
                end
        end

endmodule

`default_nettype wire

/* verilog/xoodoo_sequencer.sv */
`default_nettype none

// Control for the unrolled round chain
module xoodoo_sequencer #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic                                         eph1,
        input  logic                                         reset,
        input  logic                                         start,
        input  xoodoo_pkg::state_t                           state_in,
        input  xoodoo_pkg::state_t                           state_fb,
        output xoodoo_pkg::state_t                           round_in,
        output xoodoo_pkg::lane_t [ROUNDS_PER_CYCLE-1:0]     rc,
        output logic                                         advance,
        output logic                                         last,
        output logic                                         busy
);

        // Clocks per permutation
        localparam int NUM_CYCLES = xoodoo_pkg::NUM_ROUNDS / ROUNDS_PER_CYCLE;

        // Chain length has to split the rounds evenly
        if (xoodoo_pkg::NUM_ROUNDS % ROUNDS_PER_CYCLE != 0) begin : g_bad_rpc
                $error("ROUNDS_PER_CYCLE must divide NUM_ROUNDS");
        end

        xoodoo_pkg::seq_state_t seq_state;
        xoodoo_pkg::round_idx_t cycle_ctr;
        logic                   accept;

        // ----------------------------------------------------------------------
        // Strobes to the state register
        // ----------------------------------------------------------------------

        // Start only counts when idle; starts during a run are dropped
        assign accept = (seq_state == xoodoo_pkg::SEQ_IDLE) & start;

        // Capture on the accepting cycle and on every run cycle
        assign advance = accept | (seq_state == xoodoo_pkg::SEQ_RUN);

        // Counter sits at 0 while idle, so a one-cycle permutation ends on accept
        assign last = advance & (cycle_ctr == xoodoo_pkg::round_idx_t'(NUM_CYCLES - 1));

        assign busy = (seq_state == xoodoo_pkg::SEQ_RUN);

        // ----------------------------------------------------------------------
        // FSM and cycle counter
        // ----------------------------------------------------------------------
        always_ff @(posedge eph1) begin
                if (reset) begin
                        seq_state <= xoodoo_pkg::SEQ_IDLE;
                        cycle_ctr <= '0;
                end else if (advance) begin
                        if (last) begin
                                // Back to idle, counter rearmed for next start
                                seq_state <= xoodoo_pkg::SEQ_IDLE;
                                cycle_ctr <= '0;
                        end else begin
                                seq_state <= xoodoo_pkg::SEQ_RUN;
                                cycle_ctr <= cycle_ctr + 1'b1;
                        end
                end
        end

        // ----------------------------------------------------------------------
        // Chain input and per-stage constants
        // ----------------------------------------------------------------------

        // Fresh state on accept, otherwise loop the register back
        assign round_in = accept ? state_in : state_fb;

        // Stage k runs round cycle_ctr*ROUNDS_PER_CYCLE + k
        always_comb begin
                for (int k = 0; k < ROUNDS_PER_CYCLE; k++) begin
                        rc[k] = xoodoo_pkg::round_constant(
                                xoodoo_pkg::round_idx_t'(int'(cycle_ctr) * ROUNDS_PER_CYCLE + k));
                end
        end

endmodule

`default_nettype wire

/* verilog/xoodoo_round.sv */
`default_nettype none

// One combinational Xoodoo round
module xoodoo_round (
        input  xoodoo_pkg::state_t state_in,
        input  xoodoo_pkg::lane_t  rc,
        output xoodoo_pkg::state_t state_out
);

        // Cyclic left rotation of one lane along z
        function automatic xoodoo_pkg::lane_t rotl(input xoodoo_pkg::lane_t v, input int n);
                rotl = (v << n) | (v >> (xoodoo_pkg::LANE_BITS - n));
        endfunction

        xoodoo_pkg::plane_t p;
        xoodoo_pkg::plane_t e;
        xoodoo_pkg::state_t theta;
        xoodoo_pkg::state_t west;
        xoodoo_pkg::state_t chi;

        // ----------------------------------------------------------------------
        // Theta
        // ----------------------------------------------------------------------
        always_comb begin
                // Column parity
                p = state_in[0] ^ state_in[1] ^ state_in[2];
                // E = P<<<(1,5) ^ P<<<(1,14); lane x takes lane x-1
                for (int x = 0; x < 4; x++) begin
                        e[x] = rotl(p[(x + 3) % 4], 5) ^ rotl(p[(x + 3) % 4], 14);
                end
                // Same effect word on all three planes
                for (int y = 0; y < 3; y++) begin
                        theta[y] = state_in[y] ^ e;
                end
        end

        // ----------------------------------------------------------------------
        // Rho-west and iota
        // ----------------------------------------------------------------------
        always_comb begin
                west[0] = theta[0];
                // Iota on lane 0 of plane 0
                west[0][0] = theta[0][0] ^ rc;
                for (int x = 0; x < 4; x++) begin
                        // Plane 1 moves one lane up in x
                        west[1][x] = theta[1][(x + 3) % 4];
                        // Plane 2 rotates 11 along z
                        west[2][x] = rotl(theta[2][x], 11);
                end
        end

        // ----------------------------------------------------------------------
        // Chi, the only nonlinear step
        // ----------------------------------------------------------------------
        always_comb begin
                chi[0] = west[0] ^ (~west[1] & west[2]);
                chi[1] = west[1] ^ (~west[2] & west[0]);
                chi[2] = west[2] ^ (~west[0] & west[1]);
        end

        // ----------------------------------------------------------------------
        // Rho-east
        // ----------------------------------------------------------------------
        always_comb begin
                // Plane 0 passes untouched
                state_out[0] = chi[0];
                for (int x = 0; x < 4; x++) begin
                        // Plane 1 rotates 1 along z
                        state_out[1][x] = rotl(chi[1][x], 1);
                        // Plane 2 moves two lanes in x, then rotates 8
                        state_out[2][x] = rotl(chi[2][(x + 2) % 4], 8);
                end
        end

endmodule

`default_nettype wire

/* verilog/xoodoo_pkg.sv */
`default_nettype none

package xoodoo_pkg;

        // ----------------------------------------------------------------------
        // Geometry of the Xoodoo state
        // ----------------------------------------------------------------------

        // Lane width, also the modulus of every z rotation
        localparam int LANE_BITS = 32;

        // Rounds in one full permutation
        localparam int NUM_ROUNDS = 12;

        // One lane, bit index is z
        typedef logic [LANE_BITS-1:0] lane_t;

        // Four lanes, index is x
        typedef lane_t [3:0] plane_t;

        // Three planes, index is y; bit i sits at z + 32*(x + 4*y)
        typedef plane_t [2:0] state_t;

        // Round number inside one permutation, 0 to 11
        typedef logic [3:0] round_idx_t;

        // Sequencer FSM states
        typedef enum logic {
                SEQ_IDLE,
                SEQ_RUN
        } seq_state_t;

        // ----------------------------------------------------------------------
        // Iota round constants, LSB at z = 0 as in the Xoodoo spec
        // ----------------------------------------------------------------------
        function automatic lane_t round_constant(input round_idx_t idx);
                case (idx)
                        4'd0:    round_constant = 32'h0000_0058;
                        4'd1:    round_constant = 32'h0000_0038;
                        4'd2:    round_constant = 32'h0000_03c0;
                        4'd3:    round_constant = 32'h0000_00d0;
                        4'd4:    round_constant = 32'h0000_0120;
                        4'd5:    round_constant = 32'h0000_0014;
                        4'd6:    round_constant = 32'h0000_0060;
                        4'd7:    round_constant = 32'h0000_002c;
                        4'd8:    round_constant = 32'h0000_0380;
                        4'd9:    round_constant = 32'h0000_00f0;
                        4'd10:   round_constant = 32'h0000_01a0;
                        4'd11:   round_constant = 32'h0000_0012;
                        default: round_constant = '0;
                endcase
        endfunction

endpackage

`default_nettype wire
